// File: hw/tcb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// TCB memory subsystem shared definitions
// - bus sizes and address map of the memory subordinates
// - wait state count and counter width
// - opcode and subordinate state enums
// - request and response structs
////////////////////////////////////////////////////////////////////////////

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // bus sizes
  //////////////////////////////////////////////////////////////////////////

  // word address and data
  localparam int adr_width = 12;
  localparam int dat_width = 32;
  // one enable per byte lane
  localparam int ben_width = dat_width / 8;

  //////////////////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////////////////

  // number of memory subordinates and their depth in words
  localparam int num_sub       = 4;
  localparam int sub_words     = 256;
  // low address bits index a word inside one subordinate
  localparam int sub_adr_width = $clog2(sub_words);
  // upper address bits name the block
  localparam int blk_width     = adr_width - sub_adr_width;
  // index of a mapped subordinate
  localparam int idx_width     = $clog2(num_sub);
  // one extra bit so the unmapped code fits
  localparam int sel_width     = idx_width + 1;
  localparam logic [sel_width-1:0] sel_none = sel_width'(num_sub);

  // wait states before a subordinate raises ready
  localparam int wait_cyc  = 2;
  localparam int cnt_width = $clog2(wait_cyc + 1);

  //////////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } tcb_op_e;

  // subordinate handshake FSM
  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_ready
  } sub_state_e;

  typedef struct packed {
    tcb_op_e                op;
    logic [adr_width-1:0]   adr;
    logic [ben_width-1:0]   ben;
    logic [dat_width-1:0]   wdt;
  } tcb_req_t;

  typedef struct packed {
    logic [dat_width-1:0]   rdt;
    logic                   err;
  } tcb_rsp_t;

endpackage

// File: hw/tcb_dec.sv
////////////////////////////////////////////////////////////////////////////
// TCB address decoder
// - steers the request valid to one memory subordinate
// - forwards that subordinate's ready, answers unmapped blocks itself
// - one-deep register of the transfer target for the response side
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_dec (
  input  logic                              bus,
  input  logic                              rst_n,
  // manager side
  input  logic                              vld,
  input  tcb_pkg::tcb_req_t                 req,
  output logic                              rdy,
  // subordinate side
  output logic [tcb_pkg::num_sub-1:0]       sub_vld,
  input  logic [tcb_pkg::num_sub-1:0]       sub_rdy,
  // to the response collector
  output logic [tcb_pkg::sel_width-1:0]     sel_q,
  output logic                              trn_q
);

  // block number from the upper address bits
  logic [tcb_pkg::blk_width-1:0] blk;
  logic [tcb_pkg::idx_width-1:0] idx;
  logic                          mapped;
  logic [tcb_pkg::sel_width-1:0] sel;
  logic                          trn;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  assign blk    = req.adr[tcb_pkg::adr_width-1:tcb_pkg::sub_adr_width];
  assign idx    = blk[tcb_pkg::idx_width-1:0];
  // blocks at or above num_sub have no memory behind them
  assign mapped = (blk < tcb_pkg::blk_width'(tcb_pkg::num_sub));
  assign sel    = mapped ? {1'b0, idx} : tcb_pkg::sel_none;

  // valid goes only to the addressed subordinate
  always_comb begin
    for (int i = 0; i < tcb_pkg::num_sub; i++) begin
      sub_vld[i] = vld && mapped && (idx == tcb_pkg::idx_width'(i));
    end
  end

  // unmapped requests complete with zero wait states
  assign rdy = mapped ? sub_rdy[idx] : vld;

  // handshake completes in this cycle
  assign trn = vld && rdy;

  ////////////////////////////////////////////////////////////////////////////
  // transfer target pipeline
  ////////////////////////////////////////////////////////////////////////////

  // sel_q names whose response appears next cycle
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      trn_q <= 1'b0;
      sel_q <= tcb_pkg::sel_none;
    end else begin
      trn_q <= trn;
      // hold the last target between transfers
      if (trn) begin
        sel_q <= sel;
      end
    end
  end

endmodule

// File: hw/tcb_sram_sub.sv
////////////////////////////////////////////////////////////////////////////
// TCB memory subordinate
// - FSM that inserts a fixed number of wait states before ready
// - word memory with byte enabled writes
// - registered response one cycle after each transfer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_sram_sub (
  input  logic                bus,
  input  logic                rst_n,
  // request
  input  logic                vld,
  input  tcb_pkg::tcb_req_t   req,
  output logic                rdy,
  // response
  output logic                rsp_vld,
  output tcb_pkg::tcb_rsp_t   rsp
);

  // handshake state and wait counter
  tcb_pkg::sub_state_e             state;
  logic [tcb_pkg::cnt_width-1:0]   cnt;
  logic                            trn;

  // storage
  logic [tcb_pkg::dat_width-1:0]     mem [tcb_pkg::sub_words];
  logic [tcb_pkg::sub_adr_width-1:0] wadr;
  logic [tcb_pkg::dat_width-1:0]     rdt_q;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // ready straight from the state, no wait on vld
  assign rdy = (state == tcb_pkg::st_ready);
  assign trn = vld && rdy;

  // counts cycles of held vld until wait_cyc is reached
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      state <= tcb_pkg::st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        tcb_pkg::st_idle: begin
          // first cycle of vld already counts
          if (vld) begin
            cnt <= tcb_pkg::cnt_width'(1);
            if (tcb_pkg::wait_cyc <= 1) begin
              state <= tcb_pkg::st_ready;
            end else begin
              state <= tcb_pkg::st_wait;
            end
          end
        end
        tcb_pkg::st_wait: begin
          // manager withdrew the request
          if (!vld) begin
            state <= tcb_pkg::st_idle;
          end else if (cnt == tcb_pkg::cnt_width'(tcb_pkg::wait_cyc - 1)) begin
            state <= tcb_pkg::st_ready;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tcb_pkg::st_ready: begin
          // ready lasts one cycle, next request counts again from idle
          state <= tcb_pkg::st_idle;
        end
        default: begin
          state <= tcb_pkg::st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory
  ////////////////////////////////////////////////////////////////////////////

  // word inside this subordinate, block bits are decoded upstream
  assign wadr = req.adr[tcb_pkg::sub_adr_width-1:0];

  // read returns the word before any write lands
  always_ff @(posedge bus) begin
    if (trn) begin
      if (req.op == tcb_pkg::op_write) begin
        for (int b = 0; b < tcb_pkg::ben_width; b++) begin
          // disabled lanes keep old bytes
          if (req.ben[b]) begin
            mem[wadr][8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end
        // write response carries no data
        rdt_q <= '0;
      end else begin
        rdt_q <= mem[wadr];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // one-cycle pulse after every transfer
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= trn;
    end
  end

  // mapped memory never errors
  assign rsp.rdt = rdt_q;
  assign rsp.err = 1'b0;

endmodule

// File: hw/tcb_rsp_mux.sv
////////////////////////////////////////////////////////////////////////////
// TCB response collector
// - picks the response of the subordinate named by the decoder
// - error response for unmapped transfers
// - holds the last response between pulses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_rsp_mux (
  input  logic                            bus,
  input  logic                            rst_n,
  // transfer target from the decoder
  input  logic [tcb_pkg::sel_width-1:0]   sel_q,
  input  logic                            trn_q,
  // subordinate responses
  input  logic [tcb_pkg::num_sub-1:0]     sub_rsp_vld,
  input  tcb_pkg::tcb_rsp_t               sub_rsp [tcb_pkg::num_sub],
  // manager side
  output logic                            rsp_vld,
  output tcb_pkg::tcb_rsp_t               rsp
);

  logic [tcb_pkg::idx_width-1:0] idx;
  logic                          mapped;
  logic                          sel_vld;
  tcb_pkg::tcb_rsp_t             sel_rsp;
  // last response seen on the port
  tcb_pkg::tcb_rsp_t             rsp_q;

  assign idx    = sel_q[tcb_pkg::idx_width-1:0];
  assign mapped = (sel_q != tcb_pkg::sel_none);

  ////////////////////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (mapped) begin
      sel_vld = sub_rsp_vld[idx];
      sel_rsp = sub_rsp[idx];
    end else begin
      // decoder answered this one, timed by its transfer strobe
      sel_vld     = trn_q;
      sel_rsp.rdt = '0;
      sel_rsp.err = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output
  ////////////////////////////////////////////////////////////////////////////

  // capture on every pulse
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else if (sel_vld) begin
      rsp_q <= sel_rsp;
    end
  end

  // valid in the same cycle as the source
  assign rsp_vld = sel_vld;
  // live value on the pulse, held value otherwise
  assign rsp     = sel_vld ? sel_rsp : rsp_q;

endmodule

// File: hw/tcb_top.sv
////////////////////////////////////////////////////////////////////////////
// TCB memory subsystem top level
// - address decoder
// - array of memory subordinates
// - response collector
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_top (
  input  logic                bus,
  input  logic                rst_n,
  // manager port
  input  logic                vld,
  input  tcb_pkg::tcb_req_t   req,
  output logic                rdy,
  output logic                rsp_vld,
  output tcb_pkg::tcb_rsp_t   rsp
);

  // decoder to subordinates
  logic [tcb_pkg::num_sub-1:0]   sub_vld;
  logic [tcb_pkg::num_sub-1:0]   sub_rdy;
  // subordinates to collector
  logic [tcb_pkg::num_sub-1:0]   sub_rsp_vld;
  tcb_pkg::tcb_rsp_t             sub_rsp [tcb_pkg::num_sub];
  // decoder to collector
  logic [tcb_pkg::sel_width-1:0] sel_q;
  logic                          trn_q;

  tcb_dec i_dec (
    .bus     (bus),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .sub_vld (sub_vld),
    .sub_rdy (sub_rdy),
    .sel_q   (sel_q),
    .trn_q   (trn_q)
  );

  // request payload goes to every subordinate, only vld is steered
  for (genvar i = 0; i < tcb_pkg::num_sub; i++) begin : gen_sub
    tcb_sram_sub i_sub (
      .bus     (bus),
      .rst_n   (rst_n),
      .vld     (sub_vld[i]),
      .req     (req),
      .rdy     (sub_rdy[i]),
      .rsp_vld (sub_rsp_vld[i]),
      .rsp     (sub_rsp[i])
    );
  end

  tcb_rsp_mux i_rsp_mux (
    .bus         (bus),
    .rst_n       (rst_n),
    .sel_q       (sel_q),
    .trn_q       (trn_q),
    .sub_rsp_vld (sub_rsp_vld),
    .sub_rsp     (sub_rsp),
    .rsp_vld     (rsp_vld),
    .rsp         (rsp)
  );

endmodule

// File: test/tcb_checker.sv
////////////////////////////////////////////////////////////////////////////
// TCB memory subsystem checker, bound to the top level
// - shadow memory with per-byte written flags
// - expected response registered at each transfer
// - concurrent assertions on handshake, wait states, response and data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_checker (
  input logic                bus,
  input logic                rst_n,
  input logic                vld,
  input tcb_pkg::tcb_req_t   req,
  input logic                rdy,
  input logic                rsp_vld,
  input tcb_pkg::tcb_rsp_t   rsp
);

  // failures seen so far, read by the testbench
  int fail_cnt = 0;

  logic trn;
  logic trn_q;
  logic mapped;
  logic [7:0] wait_cnt;
  logic [7:0] exp_wait;
  logic [tcb_pkg::sub_adr_width+tcb_pkg::idx_width-1:0] sh_adr;

  // shadow of all mapped words, known marks bytes written at least once
  logic [tcb_pkg::dat_width-1:0] shadow [tcb_pkg::num_sub*tcb_pkg::sub_words];
  logic [tcb_pkg::ben_width-1:0] known  [tcb_pkg::num_sub*tcb_pkg::sub_words];

  // expected response for the cycle after a transfer
  logic [tcb_pkg::dat_width-1:0] exp_rdt_q;
  logic [tcb_pkg::dat_width-1:0] exp_mask_q;
  logic                          exp_err_q;

  // only bytes with known content are compared
  function automatic logic [tcb_pkg::dat_width-1:0] lane_mask(
    input logic [tcb_pkg::ben_width-1:0] k
  );
    logic [tcb_pkg::dat_width-1:0] m;
    for (int b = 0; b < tcb_pkg::ben_width; b++) begin
      m[8*b +: 8] = {8{k[b]}};
    end
    return m;
  endfunction

  assign trn      = vld && rdy;
  assign mapped   = req.adr < tcb_pkg::adr_width'(tcb_pkg::num_sub * tcb_pkg::sub_words);
  assign sh_adr   = req.adr[tcb_pkg::sub_adr_width+tcb_pkg::idx_width-1:0];
  // unmapped blocks answer at once
  assign exp_wait = mapped ? 8'(tcb_pkg::wait_cyc) : 8'd0;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      trn_q      <= 1'b0;
      wait_cnt   <= 8'd0;
      exp_rdt_q  <= '0;
      exp_mask_q <= '0;
      exp_err_q  <= 1'b0;
      for (int i = 0; i < tcb_pkg::num_sub*tcb_pkg::sub_words; i++) begin
        known[i] <= '0;
      end
    end else begin
      trn_q <= trn;
      // cycles of held vld since the request began
      if (trn) begin
        wait_cnt <= 8'd0;
      end else if (vld) begin
        wait_cnt <= wait_cnt + 8'd1;
      end
      if (trn) begin
        exp_err_q <= !mapped;
        if (!mapped || req.op == tcb_pkg::op_write) begin
          // writes and errors return zero data
          exp_rdt_q  <= '0;
          exp_mask_q <= '1;
        end else begin
          exp_rdt_q  <= shadow[sh_adr];
          exp_mask_q <= lane_mask(known[sh_adr]);
        end
        if (mapped && req.op == tcb_pkg::op_write) begin
          for (int b = 0; b < tcb_pkg::ben_width; b++) begin
            if (req.ben[b]) begin
              shadow[sh_adr][8*b +: 8] <= req.wdt[8*b +: 8];
              known[sh_adr][b]         <= 1'b1;
            end
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  a_rdy_idle: assert property (@(posedge bus) disable iff (!rst_n) !vld |-> !rdy)
    else begin
      fail_cnt++;
      $error("Fail %0t: rdy high without vld", $time);
    end

  a_wait: assert property (@(posedge bus) disable iff (!rst_n) trn |-> wait_cnt == exp_wait)
    else begin
      fail_cnt++;
      $error("Fail %0t: transfer after %0d wait states, expected %0d",
             $time, wait_cnt, exp_wait);
    end

  // one pulse per transfer, and none without one
  a_rsp_vld: assert property (@(posedge bus) disable iff (!rst_n) rsp_vld == trn_q)
    else begin
      fail_cnt++;
      $error("Fail %0t: rsp_vld %0b one cycle after transfer %0b", $time, rsp_vld, trn_q);
    end

  a_err: assert property (@(posedge bus) disable iff (!rst_n)
    rsp_vld |-> rsp.err == exp_err_q)
    else begin
      fail_cnt++;
      $error("Fail %0t: err %0b, expected %0b", $time, rsp.err, exp_err_q);
    end

  a_rdt: assert property (@(posedge bus) disable iff (!rst_n)
    rsp_vld |-> ((rsp.rdt ^ exp_rdt_q) & exp_mask_q) == '0)
    else begin
      fail_cnt++;
      $error("Fail %0t: rdt %08h, expected %08h mask %08h",
             $time, rsp.rdt, exp_rdt_q, exp_mask_q);
    end

endmodule

bind tcb_top tcb_checker i_checker (
  .bus     (bus),
  .rst_n   (rst_n),
  .vld     (vld),
  .req     (req),
  .rdy     (rdy),
  .rsp_vld (rsp_vld),
  .rsp     (rsp)
);

// File: test/tcb_tb.sv
////////////////////////////////////////////////////////////////////////////
// TCB memory subsystem testbench
// - clock, reset and manager side stimulus tasks
// - directed tests per subordinate, then a random mixed sequence
// - watchdog, per-test report lines and closing counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_tb;

  logic              bus = 1'b0;
  logic              rst_n;
  logic              vld;
  tcb_pkg::tcb_req_t req;
  logic              rdy;
  logic              rsp_vld;
  tcb_pkg::tcb_rsp_t rsp;

  logic [31:0] rnd = 32'd94;
  int rand_len  = 300;
  int n_test    = 0;
  int n_pass    = 0;
  int fail_mark = 0;

  tcb_top i_dut (
    .bus     (bus),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  // 8 ns period
  always #4 bus = ~bus;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // called 1 ns after an edge and returns 1 ns after the transfer edge
  task automatic transfer(input tcb_pkg::tcb_op_e op, input int adr,
                          input logic [tcb_pkg::ben_width-1:0] ben,
                          input logic [tcb_pkg::dat_width-1:0] wdt);
    vld     = 1'b1;
    req.op  = op;
    req.adr = tcb_pkg::adr_width'(adr);
    req.ben = ben;
    req.wdt = wdt;
    // rdy is settled at the falling edge
    @(negedge bus);
    while (!rdy) begin
      @(negedge bus);
    end
    @(posedge bus);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    vld = 1'b0;
    repeat (n) begin
      @(posedge bus);
      #1;
    end
  endtask

  task automatic report_test(input string name);
    int new_fail;
    new_fail  = i_dut.i_checker.fail_cnt - fail_mark;
    fail_mark = i_dut.i_checker.fail_cnt;
    n_test++;
    if (new_fail == 0) begin
      n_pass++;
      $display("test %0d %s: pass", n_test, name);
    end else begin
      $display("test %0d %s: fail, %0d assertion failures", n_test, name, new_fail);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    int limit;
    // directed transfers plus the random run with room for a gap on each
    limit = (5 + 16 + 16 + 8 + rand_len) * (tcb_pkg::wait_cyc + 4) + 200;
    repeat (limit) @(posedge bus);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int adr;
    int gap;
    logic unm;
    rst_n = 1'b0;
    vld   = 1'b0;
    req   = '0;
    repeat (3) @(posedge bus);
    #1;
    rst_n = 1'b1;

    // nothing moves without vld
    idle_cycles(6);
    report_test("reset_idle");

    // one isolated read per subordinate and then one unmapped
    for (int s = 0; s < tcb_pkg::num_sub; s++) begin
      transfer(tcb_pkg::op_read, s * tcb_pkg::sub_words + 5, 4'hF, '0);
      idle_cycles(3);
    end
    transfer(tcb_pkg::op_read, 'hA00, 4'hF, '0);
    idle_cycles(3);
    report_test("wait_states");

    for (int s = 0; s < tcb_pkg::num_sub; s++) begin
      for (int k = 0; k < 2; k++) begin
        adr = s * tcb_pkg::sub_words + 16 + k * 37;
        rnd = xorshift(rnd);
        transfer(tcb_pkg::op_write, adr, 4'hF, rnd);
        idle_cycles(1);
        transfer(tcb_pkg::op_read, adr, 4'hF, '0);
        idle_cycles(2);
      end
    end
    report_test("write_read");

    // full word write and then two partial writes back to back
    for (int s = 0; s < tcb_pkg::num_sub; s++) begin
      adr = s * tcb_pkg::sub_words + 100;
      transfer(tcb_pkg::op_write, adr, 4'hF, 32'h1122_3344);
      transfer(tcb_pkg::op_write, adr, 4'b0101, 32'hAABB_CCDD);
      transfer(tcb_pkg::op_write, adr, 4'b1000, 32'h5566_7788);
      transfer(tcb_pkg::op_read, adr, 4'h0, '0);
      idle_cycles(2);
    end
    report_test("byte_enables");

    // zero wait states so one transfer per cycle
    for (int k = 0; k < 8; k++) begin
      rnd = xorshift(rnd);
      transfer(tcb_pkg::tcb_op_e'(k[0]), 'h400 + k * 'h155, 4'hF, rnd);
    end
    idle_cycles(3);
    report_test("unmapped");

    for (int n = 0; n < rand_len; n++) begin
      rnd = xorshift(rnd);
      // about one in eight goes beyond the mapped blocks
      unm = (rnd[12:10] == 3'b111);
      if (unm) begin
        adr = 1024 + int'(rnd[10:0]) % 3072;
      end else begin
        // few words per block so reads hit earlier writes
        adr = int'(rnd[9:8]) * tcb_pkg::sub_words + int'(rnd[3:0]);
      end
      gap = int'(rnd[15:14]) % 3;
      transfer(tcb_pkg::tcb_op_e'(rnd[16]), adr, rnd[20:17], xorshift(rnd ^ 32'h5A5A_0F0F));
      if (gap > 0) begin
        idle_cycles(gap);
      end
    end
    idle_cycles(4);
    report_test("random_mix");

    $display("%0d tests, %0d passed, %0d assertion failures",
             n_test, n_pass, i_dut.i_checker.fail_cnt);
    if (i_dut.i_checker.fail_cnt == 0 && n_pass == n_test) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
hw/tcb_pkg.sv
hw/tcb_dec.sv
hw/tcb_sram_sub.sv
hw/tcb_rsp_mux.sv
hw/tcb_top.sv
test/tcb_checker.sv
test/tcb_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the TCB memory subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timing -f project.f --top-module tcb_tb \
  --Mdir obj_dir -o tcb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# let every assertion failure be counted instead of stopping at the first one
./obj_dir/tcb_sim +verilator+error+limit+100000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
  echo "simulation reported failures, see $log"
  exit 1
fi

echo "simulation passed"
exit 0
